//--- design/rv_consts.svh
`ifndef RV_CONSTS_SVH
`define RV_CONSTS_SVH

// Major opcodes
`define F7_ITYPE    7'b0010011
`define F7_IW       7'b0011011
`define F7_RTYPE    7'b0110011
`define F7_RW       7'b0111011
`define F7_JAL      7'b1101111
`define F7_JALR     7'b1100111
`define F7_BTYPE    7'b1100011
`define F7_AUIPC    7'b0010111
`define F7_LUI      7'b0110111
`define F7_LD       7'b0000011
`define F7_SD       7'b0100011

// funct3 for integer ops
`define F3_ADD_SUB  3'b000
`define F3_SLL      3'b001
`define F3_SLT      3'b010
`define F3_SLTU     3'b011
`define F3_XOR      3'b100
`define F3_SR       3'b101
`define F3_OR       3'b110
`define F3_AND      3'b111
`define F3_ADD_SUBW 3'b000
`define F3_SLLW     3'b001
`define F3_SRW      3'b101

// funct3 for branches
`define F3_BEQ      3'b000
`define F3_BNE      3'b001
`define F3_BLT      3'b100
`define F3_BGE      3'b101
`define F3_BLTU     3'b110
`define F3_BGEU     3'b111

`define F6_LOGIC    6'b000000
`define F6_ARITH    6'b010000
`define F7_R_ADD    7'b0000000
`define F7_R_SUB    7'b0100000

`define RESET_PC    64'h0000_0000_8000_0000

`endif

//--- design/rvTypes_pkg.sv
package rvTypes_pkg;

    typedef logic [63:0] u64;    // Register or data word
    typedef logic [31:0] u32;    // Instruction word
    typedef logic [5:0]  u6;     // funct6 field
    typedef logic [4:0]  regIdx_t;

    typedef enum logic [3:0] {
        ADD  = 4'd0,
        SUB  = 4'd1,
        XOR  = 4'd2,
        OR   = 4'd3,
        AND  = 4'd4,
        SCMP = 4'd5,    // Signed less-than
        CMP  = 4'd6,    // Unsigned less-than
        LS   = 4'd7,
        RS   = 4'd8,
        SRS  = 4'd9,
        RSW  = 4'd10,   // Immediate word shifts
        SRSW = 4'd11,
        SRLW = 4'd12,   // Register word shifts
        SRAW = 4'd13,
        SLLW = 4'd14
    } aluFunc_t;

    typedef enum logic [2:0] {
        NONE  = 3'd0,
        ITYPE = 3'd1,
        RTYPE = 3'd2,
        STYPE = 3'd3,
        BTYPE = 3'd4,
        UTYPE = 3'd5,
        JTYPE = 3'd6
    } opType_t;

    typedef enum logic [2:0] {
        BRANCH_NONE = 3'd0,
        BRANCH_BEQ  = 3'd1,
        BRANCH_BNE  = 3'd2,
        BRANCH_BLT  = 3'd3,
        BRANCH_BGE  = 3'd4,
        BRANCH_BLTU = 3'd5,
        BRANCH_BGEU = 3'd6
    } branch_t;

    // log2 of the access width in bytes
    typedef enum logic [1:0] {
        MSIZE1 = 2'd0,
        MSIZE2 = 2'd1,
        MSIZE4 = 2'd2,
        MSIZE8 = 2'd3
    } msize_t;

    typedef struct packed {
        opType_t    op;
        aluFunc_t   alufunc;
        branch_t    branch;
        logic       regWrite;
        logic       selectA;        // PC as operand A
        logic       selectB;        // Immediate as operand B
        logic       extAluOut;      // Sign-extend low word of result
        logic       pcTarget;       // JALR
        logic [1:0] wbSelect;       // 00 alu, 01 mem, 10 pc+4, 11 imm
        logic [1:0] memRw;          // 01 read, 10 write
        msize_t     msize;
        logic       mem_unsigned;
    } control_t;

endpackage

//--- design/decoder.sv
`include "rv_consts.svh"

module decoder (
    input  rvTypes_pkg::u32       instr,
    output rvTypes_pkg::control_t ctl
);
    logic [6:0]     opcode;
    logic [2:0]     funct3;
    logic [6:0]     funct7;
    rvTypes_pkg::u6 funct6;

    assign opcode = instr[6:0];
    assign funct3 = instr[14:12];
    assign funct7 = instr[31:25];
    assign funct6 = instr[31:26];  // RV64 shifts use a 6-bit shamt

    always_comb begin
        ctl = '0;
        unique case (opcode)
            `F7_ITYPE, `F7_RTYPE: begin
                ctl.op       = (opcode == `F7_ITYPE) ? rvTypes_pkg::ITYPE : rvTypes_pkg::RTYPE;
                ctl.regWrite = 1'b1;
                ctl.selectB  = (opcode == `F7_ITYPE);
                unique case (funct3)
                    `F3_ADD_SUB: begin
                        // Only register form has a SUB variant
                        if (opcode == `F7_RTYPE && funct7 == `F7_R_SUB)
                            ctl.alufunc = rvTypes_pkg::SUB;
                        else
                            ctl.alufunc = rvTypes_pkg::ADD;
                    end
                    `F3_XOR:  ctl.alufunc = rvTypes_pkg::XOR;
                    `F3_OR:   ctl.alufunc = rvTypes_pkg::OR;
                    `F3_AND:  ctl.alufunc = rvTypes_pkg::AND;
                    `F3_SLT:  ctl.alufunc = rvTypes_pkg::SCMP;
                    `F3_SLTU: ctl.alufunc = rvTypes_pkg::CMP;
                    `F3_SLL:  ctl.alufunc = rvTypes_pkg::LS;
                    `F3_SR: begin
                        unique case (funct6)
                            `F6_LOGIC: ctl.alufunc = rvTypes_pkg::RS;
                            `F6_ARITH: ctl.alufunc = rvTypes_pkg::SRS;
                            default:   ctl = '0;
                        endcase
                    end
                    default: ctl = '0;
                endcase
            end
            `F7_IW: begin
                ctl.op        = rvTypes_pkg::ITYPE;
                ctl.regWrite  = 1'b1;
                ctl.selectB   = 1'b1;
                ctl.extAluOut = 1'b1;
                unique case (funct3)
                    `F3_ADD_SUBW: ctl.alufunc = rvTypes_pkg::ADD;
                    `F3_SLLW:     ctl.alufunc = rvTypes_pkg::LS;   // Low word is exact
                    `F3_SRW: begin
                        unique case (funct6)
                            `F6_LOGIC: ctl.alufunc = rvTypes_pkg::RSW;
                            `F6_ARITH: ctl.alufunc = rvTypes_pkg::SRSW;
                            default:   ctl = '0;
                        endcase
                    end
                    default: ctl = '0;
                endcase
            end
            `F7_RW: begin
                ctl.op        = rvTypes_pkg::RTYPE;
                ctl.regWrite  = 1'b1;
                ctl.extAluOut = 1'b1;
                unique case (funct3)
                    `F3_ADD_SUBW: begin
                        unique case (funct7)
                            `F7_R_ADD: ctl.alufunc = rvTypes_pkg::ADD;
                            `F7_R_SUB: ctl.alufunc = rvTypes_pkg::SUB;
                            default:   ctl = '0;
                        endcase
                    end
                    `F3_SLLW: ctl.alufunc = rvTypes_pkg::SLLW;
                    `F3_SRW: begin
                        unique case (funct6)
                            `F6_LOGIC: ctl.alufunc = rvTypes_pkg::SRLW;
                            `F6_ARITH: ctl.alufunc = rvTypes_pkg::SRAW;
                            default:   ctl = '0;
                        endcase
                    end
                    default: ctl = '0;
                endcase
            end
            `F7_JAL: begin
                ctl.op       = rvTypes_pkg::JTYPE;
                ctl.regWrite = 1'b1;
                ctl.wbSelect = 2'b10;
            end
            `F7_JALR: begin
                ctl.op       = rvTypes_pkg::ITYPE;
                ctl.pcTarget = 1'b1;
                ctl.regWrite = 1'b1;
                ctl.selectB  = 1'b1;
                ctl.wbSelect = 2'b10;
            end
            `F7_BTYPE: begin
                ctl.op      = rvTypes_pkg::BTYPE;
                ctl.alufunc = rvTypes_pkg::SUB;
                unique case (funct3)
                    `F3_BEQ:  ctl.branch = rvTypes_pkg::BRANCH_BEQ;
                    `F3_BNE:  ctl.branch = rvTypes_pkg::BRANCH_BNE;
                    `F3_BLT:  ctl.branch = rvTypes_pkg::BRANCH_BLT;
                    `F3_BGE:  ctl.branch = rvTypes_pkg::BRANCH_BGE;
                    `F3_BLTU: ctl.branch = rvTypes_pkg::BRANCH_BLTU;
                    `F3_BGEU: ctl.branch = rvTypes_pkg::BRANCH_BGEU;
                    default:  ctl = '0;
                endcase
            end
            `F7_AUIPC: begin
                ctl.op       = rvTypes_pkg::UTYPE;
                ctl.regWrite = 1'b1;
                ctl.selectA  = 1'b1;
                ctl.selectB  = 1'b1;
            end
            `F7_LUI: begin
                ctl.op       = rvTypes_pkg::UTYPE;
                ctl.regWrite = 1'b1;
                ctl.wbSelect = 2'b11;
            end
            `F7_LD, `F7_SD: begin
                ctl.op           = (opcode == `F7_LD) ? rvTypes_pkg::ITYPE : rvTypes_pkg::STYPE;
                ctl.regWrite     = (opcode == `F7_LD);
                ctl.selectB      = 1'b1;
                ctl.wbSelect     = (opcode == `F7_LD) ? 2'b01 : 2'b00;
                ctl.memRw        = (opcode == `F7_LD) ? 2'b01 : 2'b10;
                ctl.msize        = rvTypes_pkg::msize_t'(funct3[1:0]);
                ctl.mem_unsigned = funct3[2];
                // No unsigned doubleword load, no unsigned stores
                if (funct3 == 3'b111 || (opcode == `F7_SD && funct3[2]))
                    ctl = '0;
            end
            default: ctl = '0;
        endcase
    end

endmodule

//--- design/immGen.sv
module immGen (
    input  rvTypes_pkg::u32       instr,
    input  rvTypes_pkg::control_t ctl,
    output rvTypes_pkg::u64       imm
);
    logic sign;

    assign sign = instr[31];

    always_comb begin
        unique case (ctl.op)
            rvTypes_pkg::ITYPE:
                imm = {{52{sign}}, instr[31:20]};
            rvTypes_pkg::STYPE:
                imm = {{52{sign}}, instr[31:25], instr[11:7]};
            rvTypes_pkg::BTYPE:
                imm = {{51{sign}}, instr[31], instr[7], instr[30:25], instr[11:8], 1'b0};
            rvTypes_pkg::UTYPE:
                imm = {{32{sign}}, instr[31:12], 12'b0};
            rvTypes_pkg::JTYPE:
                imm = {{43{sign}}, instr[31], instr[19:12], instr[20], instr[30:21], 1'b0};
            default:
                imm = '0;   // R-type has no immediate
        endcase
    end

endmodule

//--- design/regFile.sv
module regFile (
    input  logic                clk,
    input  logic                rst,
    input  logic                we,
    input  rvTypes_pkg::regIdx_t rs1,
    input  rvTypes_pkg::regIdx_t rs2,
    input  rvTypes_pkg::regIdx_t rd,
    input  rvTypes_pkg::u64      wdata,
    output rvTypes_pkg::u64      rs1Data,
    output rvTypes_pkg::u64      rs2Data
);
    rvTypes_pkg::u64 regs [1:31];   // x0 is not stored

    assign rs1Data = (rs1 == 5'd0) ? '0 : regs[rs1];
    assign rs2Data = (rs2 == 5'd0) ? '0 : regs[rs2];

    always_ff @(posedge clk) begin
        if (rst) begin
            for (int i = 1; i < 32; i++)
                regs[i] <= '0;
        end else if (we && rd != 5'd0) begin
            regs[rd] <= wdata;
        end
    end

endmodule

//--- design/alu.sv
module alu (
    input  rvTypes_pkg::control_t ctl,
    input  rvTypes_pkg::u64       rs1Data,
    input  rvTypes_pkg::u64       rs2Data,
    input  rvTypes_pkg::u64       imm,
    input  rvTypes_pkg::u64       pc,
    output rvTypes_pkg::u64       aluOut
);
    rvTypes_pkg::u64 opA;
    rvTypes_pkg::u64 opB;
    rvTypes_pkg::u64 result;
    rvTypes_pkg::u32 srlWord;
    rvTypes_pkg::u32 sraWord;
    rvTypes_pkg::u32 sllWord;

    assign opA = ctl.selectA ? pc : rs1Data;
    assign opB = ctl.selectB ? imm : rs2Data;

    // Word shifts see only the low word and a 5-bit amount
    assign srlWord = opA[31:0] >> opB[4:0];
    assign sraWord = $signed(opA[31:0]) >>> opB[4:0];
    assign sllWord = opA[31:0] << opB[4:0];

    always_comb begin
        unique case (ctl.alufunc)
            rvTypes_pkg::ADD:  result = opA + opB;
            rvTypes_pkg::SUB:  result = opA - opB;
            rvTypes_pkg::XOR:  result = opA ^ opB;
            rvTypes_pkg::OR:   result = opA | opB;
            rvTypes_pkg::AND:  result = opA & opB;
            rvTypes_pkg::SCMP: result = {63'b0, $signed(opA) < $signed(opB)};
            rvTypes_pkg::CMP:  result = {63'b0, opA < opB};
            rvTypes_pkg::LS:   result = opA << opB[5:0];
            rvTypes_pkg::RS:   result = opA >> opB[5:0];
            rvTypes_pkg::SRS:  result = $signed(opA) >>> opB[5:0];
            rvTypes_pkg::RSW,
            rvTypes_pkg::SRLW: result = {32'b0, srlWord};
            rvTypes_pkg::SRSW,
            rvTypes_pkg::SRAW: result = {32'b0, sraWord};
            rvTypes_pkg::SLLW: result = {32'b0, sllWord};
            default:           result = '0;
        endcase
    end

    assign aluOut = ctl.extAluOut ? {{32{result[31]}}, result[31:0]} : result;

endmodule

//--- design/pcUnit.sv
`include "rv_consts.svh"

module pcUnit (
    input  logic                  clk,
    input  logic                  rst,
    input  logic                  advance,
    input  rvTypes_pkg::control_t ctl,
    input  rvTypes_pkg::u64       rs1Data,
    input  rvTypes_pkg::u64       rs2Data,
    input  rvTypes_pkg::u64       imm,
    input  rvTypes_pkg::u64       aluOut,
    output rvTypes_pkg::u64       pc,
    output rvTypes_pkg::u64       pcPlus4
);
    logic            taken;
    rvTypes_pkg::u64 nextPc;

    always_comb begin
        unique case (ctl.branch)
            rvTypes_pkg::BRANCH_BEQ:  taken = (rs1Data == rs2Data);
            rvTypes_pkg::BRANCH_BNE:  taken = (rs1Data != rs2Data);
            rvTypes_pkg::BRANCH_BLT:  taken = ($signed(rs1Data) < $signed(rs2Data));
            rvTypes_pkg::BRANCH_BGE:  taken = ($signed(rs1Data) >= $signed(rs2Data));
            rvTypes_pkg::BRANCH_BLTU: taken = (rs1Data < rs2Data);
            rvTypes_pkg::BRANCH_BGEU: taken = (rs1Data >= rs2Data);
            default:                  taken = 1'b0;
        endcase
    end

    assign pcPlus4 = pc + 64'd4;

    always_comb begin
        if (ctl.pcTarget)
            nextPc = {aluOut[63:1], 1'b0};  // JALR
        else if (taken || ctl.op == rvTypes_pkg::JTYPE)
            nextPc = pc + imm;
        else
            nextPc = pcPlus4;
    end

    always_ff @(posedge clk) begin
        if (rst)
            pc <= `RESET_PC;
        else if (advance)
            pc <= nextPc;
    end

endmodule

//--- design/writeBack.sv
module writeBack (
    input  rvTypes_pkg::control_t ctl,
    input  rvTypes_pkg::u64       aluOut,
    input  rvTypes_pkg::u64       pcPlus4,
    input  rvTypes_pkg::u64       imm,
    input  rvTypes_pkg::u64       loadData,
    output rvTypes_pkg::u64       wbData
);
    rvTypes_pkg::u64 shifted;
    rvTypes_pkg::u64 loadVal;
    logic            uns;

    // Byte lane of the address moves to bit 0
    assign shifted = loadData >> {aluOut[2:0], 3'b000};
    assign uns     = ctl.mem_unsigned;

    always_comb begin
        unique case (ctl.msize)
            rvTypes_pkg::MSIZE1: loadVal = {{56{~uns & shifted[7]}}, shifted[7:0]};
            rvTypes_pkg::MSIZE2: loadVal = {{48{~uns & shifted[15]}}, shifted[15:0]};
            rvTypes_pkg::MSIZE4: loadVal = {{32{~uns & shifted[31]}}, shifted[31:0]};
            default:             loadVal = shifted;
        endcase
    end

    always_comb begin
        unique case (ctl.wbSelect)
            2'b01:   wbData = loadVal;
            2'b10:   wbData = pcPlus4;      // Link address
            2'b11:   wbData = imm;
            default: wbData = aluOut;
        endcase
    end

endmodule

//--- design/execCore.sv
module execCore (
    input  logic                clk,
    input  logic                rst,
    input  rvTypes_pkg::u32     instr,
    input  logic                instrValid,
    input  rvTypes_pkg::u64     loadData,
    output rvTypes_pkg::u64     pc,
    output rvTypes_pkg::u64     memAddr,
    output rvTypes_pkg::u64     memWriteData,
    output logic [1:0]          memRw,
    output rvTypes_pkg::msize_t memSize
);
    rvTypes_pkg::control_t ctl;
    rvTypes_pkg::u64       rs1Data;
    rvTypes_pkg::u64       rs2Data;
    rvTypes_pkg::u64       imm;
    rvTypes_pkg::u64       aluOut;
    rvTypes_pkg::u64       pcPlus4;
    rvTypes_pkg::u64       wbData;
    rvTypes_pkg::regIdx_t  rs1;
    rvTypes_pkg::regIdx_t  rs2;
    rvTypes_pkg::regIdx_t  rd;

    assign rs1 = instr[19:15];
    assign rs2 = instr[24:20];
    assign rd  = instr[11:7];

    decoder u_decoder (.instr(instr), .ctl(ctl));

    immGen u_immGen (.instr(instr), .ctl(ctl), .imm(imm));

    regFile u_regFile (
        .clk(clk), .rst(rst), .we(ctl.regWrite & instrValid),
        .rs1(rs1), .rs2(rs2), .rd(rd), .wdata(wbData),
        .rs1Data(rs1Data), .rs2Data(rs2Data)
    );

    alu u_alu (
        .ctl(ctl), .rs1Data(rs1Data), .rs2Data(rs2Data),
        .imm(imm), .pc(pc), .aluOut(aluOut)
    );

    pcUnit u_pcUnit (
        .clk(clk), .rst(rst), .advance(instrValid), .ctl(ctl),
        .rs1Data(rs1Data), .rs2Data(rs2Data), .imm(imm), .aluOut(aluOut),
        .pc(pc), .pcPlus4(pcPlus4)
    );

    writeBack u_writeBack (
        .ctl(ctl), .aluOut(aluOut), .pcPlus4(pcPlus4),
        .imm(imm), .loadData(loadData), .wbData(wbData)
    );

    // Memory request, idle when no instruction is presented
    assign memAddr      = aluOut;
    assign memWriteData = rs2Data;
    assign memRw        = instrValid ? ctl.memRw : 2'b00;
    assign memSize      = ctl.msize;

endmodule

//--- bench/execCore_tb.sv
`include "rv_consts.svh"

module execCore_tb;

    logic                clk;
    logic                rst;
    rvTypes_pkg::u32     instr;
    logic                instrValid;
    rvTypes_pkg::u64     loadData;
    rvTypes_pkg::u64     pc;
    rvTypes_pkg::u64     memAddr;
    rvTypes_pkg::u64     memWriteData;
    logic [1:0]          memRw;
    rvTypes_pkg::msize_t memSize;

    rvTypes_pkg::u64 modelRegs [32];   // Expected architectural state
    rvTypes_pkg::u64 modelPc;
    logic [31:0]     seed = 32'h9ab4_788b;
    int              errors = 0;
    int              checks = 0;

    execCore u_dut (
        .clk(clk), .rst(rst), .instr(instr), .instrValid(instrValid),
        .loadData(loadData), .pc(pc), .memAddr(memAddr),
        .memWriteData(memWriteData), .memRw(memRw), .memSize(memSize)
    );

    initial begin
        clk = 1'b0;
        forever #2 clk = ~clk;
    end

    function automatic logic [31:0] nextRand();
        seed = seed * 32'd1664525 + 32'd1013904223;
        return seed;
    endfunction

    function automatic rvTypes_pkg::u32 encI(input logic [11:0] imm, input logic [4:0] rs1,
                                             input logic [2:0] f3, input logic [4:0] rd,
                                             input logic [6:0] op);
        return {imm, rs1, f3, rd, op};
    endfunction

    function automatic rvTypes_pkg::u32 encS(input logic [11:0] imm, input logic [4:0] rs2,
                                             input logic [4:0] rs1, input logic [2:0] f3);
        return {imm[11:5], rs2, rs1, f3, imm[4:0], `F7_SD};
    endfunction

    function automatic rvTypes_pkg::u32 encB(input logic [12:0] imm, input logic [4:0] rs2,
                                             input logic [4:0] rs1, input logic [2:0] f3);
        return {imm[12], imm[10:5], rs2, rs1, f3, imm[4:1], imm[11], `F7_BTYPE};
    endfunction

    // Integer op result as the ISA defines it
    function automatic rvTypes_pkg::u64 refAlu(input logic [2:0] f3, input logic alt,
                                               input logic word, input rvTypes_pkg::u64 a,
                                               input rvTypes_pkg::u64 b);
        rvTypes_pkg::u64 r;
        logic [31:0]     lo;
        int              sh;
        sh = word ? b[4:0] : b[5:0];
        lo = a[31:0];
        case (f3)
            3'b000: r = alt ? a - b : a + b;
            3'b001: r = a << sh;
            3'b010: r = ($signed(a) < $signed(b)) ? 64'd1 : 64'd0;
            3'b011: r = (a < b) ? 64'd1 : 64'd0;
            3'b100: r = a ^ b;
            3'b101: begin
                if (word && alt)
                    lo = $signed(lo) >>> sh;
                else if (word)
                    lo = lo >> sh;
                else if (alt)
                    r = $signed(a) >>> sh;
                else
                    r = a >> sh;
                if (word)
                    r = {32'b0, lo};
            end
            3'b110: r = a | b;
            default: r = a & b;
        endcase
        if (word)
            r = {{32{r[31]}}, r[31:0]};
        return r;
    endfunction

    task automatic checkVal(input rvTypes_pkg::u64 got, input rvTypes_pkg::u64 exp,
                            input string what);
        checks++;
        if (got !== exp) begin
            errors++;
            $display("ERR t=%0t %s: got %h, expected %h", $time, what, got, exp);
        end
    endtask

    task automatic writeReg(input logic [4:0] rd, input rvTypes_pkg::u64 val);
        if (rd != 5'd0)
            modelRegs[rd] = val;
    endtask

    // One instruction per cycle, outputs sampled mid-cycle
    task automatic issue(input rvTypes_pkg::u32 ins, input rvTypes_pkg::u64 ld);
        @(negedge clk);
        instr = ins;
        instrValid = 1'b1;
        loadData = ld;
        #1;
        checkVal(pc, modelPc, "pc");
    endtask

    task automatic setReg(input logic [4:0] rd, input rvTypes_pkg::u64 val);
        issue(encI(12'd0, 5'd0, 3'b011, rd, `F7_LD), val);
        writeReg(rd, val);
        modelPc += 4;
    endtask

    task automatic storeCheck(input logic [4:0] r);
        issue(encS(12'h010, r, 5'd0, 3'b011), '0);
        checkVal(memRw, 2'b10, "store memRw");
        checkVal(memAddr, 64'h10, "store memAddr");
        checkVal(memWriteData, modelRegs[r], $sformatf("x%0d", r));
        modelPc += 4;
    endtask

    task automatic opImm(input logic [2:0] f3, input logic [4:0] rd, input logic [4:0] rs1,
                         input logic [11:0] imm, input logic word);
        rvTypes_pkg::u64 res;
        logic            alt;
        alt = (f3 == 3'b101) ? imm[10] : 1'b0;   // SRAI marker bit
        res = refAlu(f3, alt, word, modelRegs[rs1], {{52{imm[11]}}, imm});
        issue(encI(imm, rs1, f3, rd, word ? `F7_IW : `F7_ITYPE), '0);
        writeReg(rd, res);
        modelPc += 4;
    endtask

    task automatic opReg(input logic [2:0] f3, input logic alt, input logic [4:0] rd,
                         input logic [4:0] rs1, input logic [4:0] rs2, input logic word);
        rvTypes_pkg::u64 res;
        res = refAlu(f3, alt, word, modelRegs[rs1], modelRegs[rs2]);
        issue({alt ? `F7_R_SUB : `F7_R_ADD, rs2, rs1, f3, rd, word ? `F7_RW : `F7_RTYPE}, '0);
        writeReg(rd, res);
        modelPc += 4;
    endtask

    task automatic loadCheck(input logic [2:0] f3, input logic [4:0] rd,
                             input logic [11:0] off, input rvTypes_pkg::u64 pat);
        rvTypes_pkg::u64 addr;
        rvTypes_pkg::u64 lane;
        rvTypes_pkg::u64 exp;
        addr = modelRegs[15] + {{52{off[11]}}, off};
        lane = pat >> (8 * addr[2:0]);
        case (f3)
            3'b000: exp = {{56{lane[7]}}, lane[7:0]};
            3'b100: exp = {56'b0, lane[7:0]};
            3'b001: exp = {{48{lane[15]}}, lane[15:0]};
            3'b101: exp = {48'b0, lane[15:0]};
            3'b010: exp = {{32{lane[31]}}, lane[31:0]};
            3'b110: exp = {32'b0, lane[31:0]};
            default: exp = lane;
        endcase
        issue(encI(off, 5'd15, f3, rd, `F7_LD), pat);
        checkVal(memRw, 2'b01, "load memRw");
        checkVal(memAddr, addr, "load memAddr");
        checkVal(memSize, f3[1:0], "load memSize");
        writeReg(rd, exp);
        modelPc += 4;
        storeCheck(rd);
    endtask

    task automatic branch(input logic [2:0] f3, input logic [4:0] rs1, input logic [4:0] rs2,
                          input logic [12:0] off);
        rvTypes_pkg::u64 a;
        rvTypes_pkg::u64 b;
        logic            taken;
        a = modelRegs[rs1];
        b = modelRegs[rs2];
        case (f3)
            3'b000: taken = (a == b);
            3'b001: taken = (a != b);
            3'b100: taken = ($signed(a) < $signed(b));
            3'b101: taken = ($signed(a) >= $signed(b));
            3'b110: taken = (a < b);
            default: taken = (a >= b);
        endcase
        issue(encB(off, rs2, rs1, f3), '0);
        modelPc = taken ? modelPc + {{51{off[12]}}, off} : modelPc + 4;
    endtask

    task automatic jump(input logic [4:0] rd, input logic [20:0] off);
        issue({off[20], off[10:1], off[11], off[19:12], rd, `F7_JAL}, '0);
        writeReg(rd, modelPc + 4);
        modelPc += {{43{off[20]}}, off};
    endtask

    task automatic jumpReg(input logic [4:0] rd, input logic [4:0] rs1, input logic [11:0] imm);
        rvTypes_pkg::u64 target;
        target = (modelRegs[rs1] + {{52{imm[11]}}, imm}) & ~64'd1;   // Before rd is written
        issue(encI(imm, rs1, 3'b000, rd, `F7_JALR), '0);
        writeReg(rd, modelPc + 4);
        modelPc = target;
    endtask

    task automatic upperOp(input logic [4:0] rd, input logic [19:0] imm, input logic auipc);
        rvTypes_pkg::u64 val;
        val = {{32{imm[19]}}, imm, 12'b0};
        issue({imm, rd, auipc ? `F7_AUIPC : `F7_LUI}, '0);
        writeReg(rd, auipc ? modelPc + val : val);
        modelPc += 4;
    endtask

    task automatic testReset();
        int n;
        n = 0;
        while (pc !== `RESET_PC && n < 10) begin
            @(negedge clk);
            n++;
        end
        if (pc !== `RESET_PC) begin
            errors++;
            $display("PC did not reach its reset value after reset");
        end
        @(negedge clk);
        instr = encI(12'd8, 5'd0, 3'b011, 5'd5, `F7_LD);   // Load held back by instrValid
        loadData = 64'h1234;
        #1;
        checkVal(memRw, 2'b00, "memRw with instrValid low");
        repeat (3) @(negedge clk);
        #1;
        checkVal(pc, `RESET_PC, "pc after idle cycles");
        storeCheck(5);
    endtask

    task automatic testArith();
        setReg(1, 64'hfedc_ba98_7654_3210);
        setReg(2, 64'h0000_0000_8000_0005);
        opImm(3'b000, 3, 1, 12'hffb, 0);
        opImm(3'b100, 4, 1, 12'h7ff, 0);
        opImm(3'b010, 5, 1, 12'd3, 0);
        opImm(3'b001, 6, 1, 12'd36, 0);
        opImm(3'b101, 7, 1, 12'd40, 0);
        opImm(3'b101, 8, 1, 12'h428, 0);    // SRAI by 40
        opReg(3'b000, 0, 9, 1, 2, 0);
        opReg(3'b000, 1, 10, 1, 2, 0);
        opImm(3'b000, 11, 2, 12'h7fb, 1);   // Word result has bit 31 set
        opReg(3'b001, 0, 12, 1, 2, 1);
        opReg(3'b101, 1, 13, 2, 2, 1);
        opImm(3'b000, 0, 1, 12'd1, 0);      // x0 must stay zero
        for (int r = 0; r <= 13; r++)
            storeCheck(r);
    endtask

    task automatic testLoads();
        rvTypes_pkg::u64 pat;
        pat = 64'h8a7b_f6e5_94c3_b281;
        setReg(15, 64'h0000_0000_0000_1000);
        loadCheck(3'b000, 14, 12'd3, pat);
        loadCheck(3'b000, 14, 12'd6, pat);
        loadCheck(3'b100, 14, 12'd7, pat);
        loadCheck(3'b001, 14, 12'd2, pat);
        loadCheck(3'b101, 14, 12'd6, pat);
        loadCheck(3'b010, 14, 12'd4, pat);
        loadCheck(3'b110, 14, 12'd4, pat);
        loadCheck(3'b011, 14, 12'hff8, pat);   // Negative offset
    endtask

    task automatic testControl();
        setReg(16, 64'hffff_ffff_ffff_fffd);
        setReg(17, 64'd5);
        branch(3'b000, 16, 16, 13'd12);
        branch(3'b000, 16, 17, 13'd12);
        branch(3'b001, 16, 17, 13'h1ff8);
        branch(3'b100, 16, 17, 13'd64);
        branch(3'b101, 16, 17, 13'd64);
        branch(3'b110, 16, 17, 13'd32);
        branch(3'b111, 16, 17, 13'h1fe0);
        jump(18, 21'd40);
        jump(23, 21'h1ffff0);
        setReg(20, 64'h0000_0000_8000_1235);
        jumpReg(19, 20, 12'd4);
        jumpReg(20, 20, 12'hffc);              // rd equals rs1
        storeCheck(18);
        storeCheck(19);
        storeCheck(20);
        storeCheck(23);
    endtask

    task automatic testUpper();
        upperOp(21, 20'h80001, 0);
        upperOp(22, 20'h12345, 1);
        upperOp(24, 20'hfffff, 1);
        storeCheck(21);
        storeCheck(22);
        storeCheck(24);
    endtask

    task automatic testRandom();
        logic [31:0] rnd;
        logic [2:0]  f3;
        logic        alt;
        logic        word;
        for (int r = 1; r < 8; r++)
            setReg(r, {nextRand(), nextRand()});
        repeat (200) begin
            rnd  = nextRand();
            f3   = rnd[19:17];
            alt  = rnd[16];
            word = rnd[15];
            if (word && f3 != 3'b001 && f3 != 3'b101)
                f3 = 3'b000;   // Only ADDW, SUBW and word shifts exist
            if (f3 != 3'b000 && f3 != 3'b101)
                alt = 1'b0;
            opReg(f3, alt, {1'b0, rnd[31:28]}, {1'b0, rnd[27:24]}, {1'b0, rnd[23:20]}, word);
            storeCheck({1'b0, rnd[31:28]});
        end
    endtask

    initial begin
        for (int c = 0; c < 5000; c++)
            @(posedge clk);
        $display("Timeout: the run did not finish within 5000 cycles");
        $display("TESTS FAILED");
        $finish;
    end

    initial begin
        rst = 1'b1;
        instr = '0;
        instrValid = 1'b0;
        loadData = '0;
        modelPc = `RESET_PC;
        for (int i = 0; i < 32; i++)
            modelRegs[i] = '0;
        repeat (5) @(posedge clk);
        @(negedge clk);
        rst = 1'b0;
        testReset();
        testArith();
        testLoads();
        testControl();
        testUpper();
        testRandom();
        @(negedge clk);
        instrValid = 1'b0;
        #1;
        checkVal(pc, modelPc, "final pc");
        $display("Checks: %0d, errors: %0d", checks, errors);
        if (errors == 0)
            $display("TESTS PASSED");
        else
            $display("TESTS FAILED");
        $finish;
    end

endmodule

//--- execCore.f
+incdir+design
design/rvTypes_pkg.sv
design/decoder.sv
design/immGen.sv
design/regFile.sv
design/alu.sv
design/pcUnit.sv
design/writeBack.sv
design/execCore.sv
bench/execCore_tb.sv
